//--- include/fp_ops_consts.svh
`ifndef FP_OPS_CONSTS_SVH
`define FP_OPS_CONSTS_SVH

// Single precision layout
`define FP_W        32
`define FP_EXP_W    8
`define FP_FRAC_W   23

// Compare result field, zero extended into the data word
`define CMP_RES_W   8

// Cycles from accepted beat to o_valid
`define OP_PIPE_DEPTH 2

// Reset value of the TLAST merge mode (pass A)
`define TLAST_MODE_RST 3'd1

`endif

//--- verilog/fp_ops_pkg.sv
`default_nettype none

`include "fp_ops_consts.svh"

package fp_ops_pkg;

    // Operand and result word
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp32_t;

    // One-hot operand class
    typedef struct packed {
        logic zero;
        logic subnormal;
        logic normal;
        logic inf;
        logic qnan;
        logic snan;
    } fp_class_t;

    typedef enum logic {
        OP_ABS     = 1'b0,
        OP_COMPARE = 1'b1
    } fp_op_e;

    typedef enum logic [2:0] {
        PRED_UNORD = 3'd0,
        PRED_LT    = 3'd1,
        PRED_EQ    = 3'd2,
        PRED_LE    = 3'd3,
        PRED_GT    = 3'd4,
        PRED_NE    = 3'd5,
        PRED_GE    = 3'd6,
        PRED_CODE  = 3'd7
    } cmp_pred_e;

    typedef enum logic [2:0] {
        TLAST_NONE = 3'd0,
        TLAST_A    = 3'd1,
        TLAST_B    = 3'd2,
        TLAST_OP   = 3'd3,
        TLAST_OR   = 3'd4,
        TLAST_AND  = 3'd5
    } tlast_mode_e;

    typedef struct packed {
        fp32_t     a;
        fp32_t     b;
        fp_op_e    op;
        cmp_pred_e pred;
        logic      tlast;
    } issue_beat_t;

endpackage

`default_nettype wire

//--- verilog/fp_classify.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_ops_consts.svh"

module fp_classify import fp_ops_pkg::*; (
    input  fp32_t     i_x,
    output fp_class_t o_class
);

    logic exp_zero;
    logic exp_ones;
    logic frac_zero;

    assign exp_zero  = (i_x.exp == '0);
    assign exp_ones  = (i_x.exp == '1);
    assign frac_zero = (i_x.frac == '0);

    assign o_class.zero      = exp_zero & frac_zero;
    assign o_class.subnormal = exp_zero & ~frac_zero;
    assign o_class.normal    = ~exp_zero & ~exp_ones;
    assign o_class.inf       = exp_ones & frac_zero;

    // NaN kind from the top fraction bit
    assign o_class.qnan = exp_ones & ~frac_zero & i_x.frac[`FP_FRAC_W-1];
    assign o_class.snan = exp_ones & ~frac_zero & ~i_x.frac[`FP_FRAC_W-1];

endmodule

`default_nettype wire

//--- verilog/fp_compare.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_ops_consts.svh"

module fp_compare import fp_ops_pkg::*; (
    input  fp32_t                 i_a,
    input  fp32_t                 i_b,
    input  cmp_pred_e             i_pred,
    output logic [`CMP_RES_W-1:0] o_result,
    output logic                  o_invalid
);

    fp_class_t                     cls_a;
    fp_class_t                     cls_b;
    logic [`FP_W-2:0]              mag_a;
    logic [`FP_W-2:0]              mag_b;
    logic                          unord;
    logic                          any_qnan;
    logic                          any_snan;
    logic                          eq;
    logic                          lt;
    logic                          gt;
    logic                          lt_raw;
    logic                          pred_bit;
    logic                          signal_on_qnan;

    fp_classify u_class_a (
        .i_x     (i_a),
        .o_class (cls_a)
    );

    fp_classify u_class_b (
        .i_x     (i_b),
        .o_class (cls_b)
    );

    assign mag_a = {i_a.exp, i_a.frac};
    assign mag_b = {i_b.exp, i_b.frac};

    assign any_qnan = cls_a.qnan | cls_b.qnan;
    assign any_snan = cls_a.snan | cls_b.snan;
    assign unord    = any_qnan | any_snan;

    ////////////////////////////////////////////////////////////
    // Ordering
    ////////////////////////////////////////////////////////////

    // Signed zeros compare equal
    assign eq = ~unord & ((cls_a.zero & cls_b.zero) || (i_a == i_b));

    always_comb begin
        if (i_a.sign != i_b.sign) begin
            lt_raw = i_a.sign;
        end else if (i_a.sign) begin
            lt_raw = mag_a > mag_b;
        end else begin
            lt_raw = mag_a < mag_b;
        end
    end

    assign lt = ~unord & ~eq & lt_raw;
    assign gt = ~unord & ~eq & ~lt_raw;

    ////////////////////////////////////////////////////////////
    // Predicate select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (i_pred)
            PRED_UNORD: pred_bit = unord;
            PRED_LT:    pred_bit = lt;
            PRED_EQ:    pred_bit = eq;
            PRED_LE:    pred_bit = lt | eq;
            PRED_GT:    pred_bit = gt;
            PRED_NE:    pred_bit = ~eq;
            PRED_GE:    pred_bit = gt | eq;
            default:    pred_bit = 1'b0;
        endcase
    end

    // Condition code is {unord, gt, lt, eq}
    assign o_result = (i_pred == PRED_CODE) ?
                      {{(`CMP_RES_W-4){1'b0}}, unord, gt, lt, eq} :
                      {{(`CMP_RES_W-1){1'b0}}, pred_bit};

    // Ordered predicates also trap on quiet NaNs
    assign signal_on_qnan = (i_pred inside {PRED_LT, PRED_LE, PRED_GT, PRED_GE, PRED_CODE});
    assign o_invalid      = any_snan | (any_qnan & signal_on_qnan);

endmodule

`default_nettype wire

//--- verilog/fp_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_ops_consts.svh"

module fp_cfg_regs import fp_ops_pkg::*; (
    input  logic        i_aclk,
    input  logic        i_aclken,
    input  logic        i_rst_n,
    input  logic        i_cfg_wr,
    input  tlast_mode_e i_cfg_tlast_mode,
    input  logic        i_invalid_pulse,
    output tlast_mode_e o_tlast_mode,
    output logic        o_invalid_sticky
);

    // Merge mode, takes effect for beats after the write edge
    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_tlast_mode <= tlast_mode_e'(`TLAST_MODE_RST);
        end else if (i_aclken && i_cfg_wr) begin
            o_tlast_mode <= i_cfg_tlast_mode;
        end
    end

    // Sticky invalid, a pulse on the same edge beats the clear
    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_invalid_sticky <= 1'b0;
        end else if (i_aclken) begin
            if (i_invalid_pulse) begin
                o_invalid_sticky <= 1'b1;
            end else if (i_cfg_wr) begin
                o_invalid_sticky <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_cfg_mode_legal: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        (i_aclken && i_cfg_wr) |->
            (i_cfg_tlast_mode inside {TLAST_NONE, TLAST_A, TLAST_B,
                                      TLAST_OP, TLAST_OR, TLAST_AND})
    );

endmodule

`default_nettype wire

//--- verilog/fp_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fp_issue_stage import fp_ops_pkg::*; (
    input  logic        i_aclk,
    input  logic        i_aclken,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  fp32_t       i_a_data,
    input  fp32_t       i_b_data,
    input  fp_op_e      i_op,
    input  cmp_pred_e   i_pred,
    input  logic        i_a_tlast,
    input  logic        i_b_tlast,
    input  logic        i_op_tlast,
    input  tlast_mode_e i_tlast_mode,
    output issue_beat_t o_beat,
    output logic        o_valid
);

    logic tlast_merged;

    // TLAST merge
    always_comb begin
        case (i_tlast_mode)
            TLAST_NONE: tlast_merged = 1'b0;
            TLAST_A:    tlast_merged = i_a_tlast;
            TLAST_B:    tlast_merged = i_b_tlast;
            TLAST_OP:   tlast_merged = i_op_tlast;
            TLAST_OR:   tlast_merged = i_a_tlast | i_b_tlast | i_op_tlast;
            TLAST_AND:  tlast_merged = i_a_tlast & i_b_tlast & i_op_tlast;
            default:    tlast_merged = 1'b0;
        endcase
    end

    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_aclken) begin
            o_valid <= i_valid;
        end
    end

    // Beat payload, only loaded on accept
    always_ff @(posedge i_aclk) begin
        if (i_aclken && i_valid) begin
            o_beat.a     <= i_a_data;
            o_beat.b     <= i_b_data;
            o_beat.op    <= i_op;
            o_beat.pred  <= i_pred;
            o_beat.tlast <= tlast_merged;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fp_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_ops_consts.svh"

module fp_result_stage import fp_ops_pkg::*; (
    input  logic                  i_aclk,
    input  logic                  i_aclken,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  issue_beat_t           i_beat,
    input  logic [`CMP_RES_W-1:0] i_cmp_result,
    input  logic                  i_cmp_invalid,
    output logic                  o_valid,
    output fp32_t                 o_data,
    output logic                  o_tlast,
    output logic                  o_invalid_op
);

    fp32_t result;
    logic  invalid;

    // Abs keeps NaN payloads, only the sign goes
    always_comb begin
        if (i_beat.op == OP_COMPARE) begin
            result = fp32_t'({{(`FP_W-`CMP_RES_W){1'b0}}, i_cmp_result});
        end else begin
            result = '{sign: 1'b0, exp: i_beat.a.exp, frac: i_beat.a.frac};
        end
    end

    assign invalid = i_valid && (i_beat.op == OP_COMPARE) && i_cmp_invalid;

    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid      <= 1'b0;
            o_tlast      <= 1'b0;
            o_invalid_op <= 1'b0;
        end else if (i_aclken) begin
            o_valid      <= i_valid;
            o_invalid_op <= invalid;
            if (i_valid) begin
                o_tlast <= i_beat.tlast;
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (i_aclken && i_valid) begin
            o_data <= result;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_invalid_needs_valid: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        o_invalid_op |-> o_valid
    );

    a_cmp_upper_zero: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        (i_aclken && i_valid && i_beat.op == OP_COMPARE) |=>
            (o_valid && o_data[`FP_W-1:`CMP_RES_W] == '0)
    );

endmodule

`default_nettype wire

//--- verilog/fp_ops_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_ops_consts.svh"

module fp_ops_top import fp_ops_pkg::*; (
    input  logic        i_aclk,
    input  logic        i_aclken,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  fp32_t       i_a_data,
    input  fp32_t       i_b_data,
    input  fp_op_e      i_op,
    input  cmp_pred_e   i_pred,
    input  logic        i_a_tlast,
    input  logic        i_b_tlast,
    input  logic        i_op_tlast,
    input  logic        i_cfg_wr,
    input  tlast_mode_e i_cfg_tlast_mode,
    output logic        o_valid,
    output fp32_t       o_data,
    output logic        o_tlast,
    output logic        o_invalid_op,
    output logic        o_invalid_sticky
);

    tlast_mode_e              tlast_mode;
    issue_beat_t              issue_beat;
    logic                     issue_valid;
    logic [`CMP_RES_W-1:0]    cmp_result;
    logic                     cmp_invalid;

    fp_cfg_regs u_cfg_regs (
        .i_aclk           (i_aclk),
        .i_aclken         (i_aclken),
        .i_rst_n          (i_rst_n),
        .i_cfg_wr         (i_cfg_wr),
        .i_cfg_tlast_mode (i_cfg_tlast_mode),
        .i_invalid_pulse  (o_invalid_op),
        .o_tlast_mode     (tlast_mode),
        .o_invalid_sticky (o_invalid_sticky)
    );

    fp_issue_stage u_issue_stage (
        .i_aclk       (i_aclk),
        .i_aclken     (i_aclken),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_a_data     (i_a_data),
        .i_b_data     (i_b_data),
        .i_op         (i_op),
        .i_pred       (i_pred),
        .i_a_tlast    (i_a_tlast),
        .i_b_tlast    (i_b_tlast),
        .i_op_tlast   (i_op_tlast),
        .i_tlast_mode (tlast_mode),
        .o_beat       (issue_beat),
        .o_valid      (issue_valid)
    );

    fp_compare u_compare (
        .i_a      (issue_beat.a),
        .i_b      (issue_beat.b),
        .i_pred   (issue_beat.pred),
        .o_result (cmp_result),
        .o_invalid(cmp_invalid)
    );

    fp_result_stage u_result_stage (
        .i_aclk        (i_aclk),
        .i_aclken      (i_aclken),
        .i_rst_n       (i_rst_n),
        .i_valid       (issue_valid),
        .i_beat        (issue_beat),
        .i_cmp_result  (cmp_result),
        .i_cmp_invalid (cmp_invalid),
        .o_valid       (o_valid),
        .o_data        (o_data),
        .o_tlast       (o_tlast),
        .o_invalid_op  (o_invalid_op)
    );

endmodule

`default_nettype wire

//--- verif/tb_fp_ops.sv
`timescale 1ns/1ps
`default_nettype none

`include "fp_ops_consts.svh"

module tb_fp_ops import fp_ops_pkg::*; ();

    localparam int CLK_NS       = 40;
    localparam int N_VEC        = 28;
    localparam int N_MODE_BEATS = 6 * 9;
    localparam int N_RAND       = 64;
    // Random beats may add a stall and a bubble each
    localparam int TIMEOUT_NS   = (N_VEC + N_MODE_BEATS + 3 * N_RAND + 20) * CLK_NS;

    // tl is {op, b, a}
    typedef struct {
        string     name;
        fp_op_e    op;
        cmp_pred_e pred;
        fp32_t     a;
        fp32_t     b;
        logic [2:0] tl;
    } vec_t;

    typedef struct {
        string name;
        fp32_t data;
        logic  tlast;
        logic  inv;
        int    due;
    } exp_beat_t;

    logic        i_aclk;
    logic        i_aclken;
    logic        i_rst_n;
    logic        i_valid;
    fp32_t       i_a_data;
    fp32_t       i_b_data;
    fp_op_e      i_op;
    cmp_pred_e   i_pred;
    logic        i_a_tlast;
    logic        i_b_tlast;
    logic        i_op_tlast;
    logic        i_cfg_wr;
    tlast_mode_e i_cfg_tlast_mode;
    logic        o_valid;
    fp32_t       o_data;
    logic        o_tlast;
    logic        o_invalid_op;
    logic        o_invalid_sticky;

    vec_t        vecs[N_VEC];
    int          n_fill;
    exp_beat_t   exp_q[$];
    tlast_mode_e cur_mode;
    logic [31:0] lcg_state;
    int          n_err;
    int          n_checks;
    int          edge_cnt;
    logic        en_at_edge;
    logic        exp_inv_out;
    logic        exp_sticky;
    logic        hold_valid;
    fp32_t       hold_data;
    logic        hold_tlast;
    logic        hold_inv;

    fp_ops_top UUT (.*);

    initial begin
        i_aclk = 1'b0;
        forever begin
            #(CLK_NS / 2) i_aclk = ~i_aclk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic is_nan(fp32_t x);
        return (x.exp == '1) && (x.frac != '0);
    endfunction

    function automatic logic is_snan(fp32_t x);
        return is_nan(x) && !x.frac[`FP_FRAC_W-1];
    endfunction

    function automatic logic is_zero(fp32_t x);
        return (x.exp == '0) && (x.frac == '0);
    endfunction

    // Monotonic unsigned key for ordered floats
    function automatic logic [31:0] order_key(fp32_t x);
        logic [31:0] raw;
        raw = x;
        return raw[31] ? ~raw : (raw | 32'h8000_0000);
    endfunction

    function automatic logic merge_tlast(tlast_mode_e mode, logic [2:0] tl);
        case (mode)
            TLAST_A:   return tl[0];
            TLAST_B:   return tl[1];
            TLAST_OP:  return tl[2];
            TLAST_OR:  return |tl;
            TLAST_AND: return &tl;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic exp_beat_t model(vec_t v);
        exp_beat_t   e;
        logic        unord;
        logic        eq;
        logic        lt;
        logic        gt;
        logic        hit;
        logic        qn;
        logic [31:0] ka;
        logic [31:0] kb;
        unord = is_nan(v.a) || is_nan(v.b);
        qn    = (is_nan(v.a) && !is_snan(v.a)) || (is_nan(v.b) && !is_snan(v.b));
        ka    = order_key(v.a);
        kb    = order_key(v.b);
        eq    = !unord && ((is_zero(v.a) && is_zero(v.b)) || ka == kb);
        lt    = !unord && !eq && (ka < kb);
        gt    = !unord && !eq && (ka > kb);
        case (v.pred)
            PRED_UNORD: hit = unord;
            PRED_LT:    hit = lt;
            PRED_EQ:    hit = eq;
            PRED_LE:    hit = lt || eq;
            PRED_GT:    hit = gt;
            PRED_NE:    hit = !eq;
            PRED_GE:    hit = gt || eq;
            default:    hit = 1'b0;
        endcase
        e.name  = v.name;
        e.tlast = merge_tlast(cur_mode, v.tl);
        e.due   = 0;
        if (v.op == OP_ABS) begin
            e.data = {1'b0, v.a.exp, v.a.frac};
            e.inv  = 1'b0;
        end else begin
            e.data = (v.pred == PRED_CODE) ? {28'd0, unord, gt, lt, eq} : {31'd0, hit};
            e.inv  = is_snan(v.a) || is_snan(v.b) ||
                     (qn && (v.pred inside {PRED_LT, PRED_LE, PRED_GT, PRED_GE, PRED_CODE}));
        end
        return e;
    endfunction

    function automatic fp32_t rand_operand();
        fp32_t       x;
        logic [31:0] s;
        x = fp32_t'(lcg_next());
        s = lcg_next();
        case (s[1:0])
            2'd0:    x.exp = '1;
            2'd1:    x.exp = '0;
            default: x.exp = x.exp;
        endcase
        if (s[3:2] == 2'b00) begin
            x.frac = '0;
        end
        return x;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_data(string name, fp32_t exp_v, fp32_t act);
        n_checks++;
        if (act !== exp_v) begin
            n_err++;
            $display("FAIL %s data: expected %h, actual %h", name, exp_v, act);
        end
    endtask

    task automatic check_tlast(string name, logic exp_v, logic act);
        n_checks++;
        if (act !== exp_v) begin
            n_err++;
            $display("FAIL %s tlast: expected %b, actual %b", name, exp_v, act);
        end
    endtask

    task automatic check_invalid(string name, logic exp_v, logic act);
        n_checks++;
        if (act !== exp_v) begin
            n_err++;
            $display("FAIL %s invalid: expected %b, actual %b", name, exp_v, act);
        end
    endtask

    always @(posedge i_aclk) begin
        en_at_edge <= i_aclken;
        if (i_aclken) begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    // Sticky flag model driven by the expected output pulse
    always @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            exp_sticky <= 1'b0;
        end else if (i_aclken) begin
            if (exp_inv_out) begin
                exp_sticky <= 1'b1;
            end else if (i_cfg_wr) begin
                exp_sticky <= 1'b0;
            end
        end
    end

    always @(negedge i_aclk) begin
        exp_beat_t e;
        if (!i_rst_n) begin
            if (o_valid !== 1'b0) begin
                n_err++;
                $display("ERROR: o_valid is not low during reset");
            end
            check_tlast("reset", 1'b0, o_tlast);
            check_invalid("reset", 1'b0, o_invalid_op);
            exp_inv_out = 1'b0;
        end else if (en_at_edge) begin
            if (o_valid === 1'b1 && exp_q.size() == 0) begin
                n_err++;
                $display("ERROR: output beat appeared with no beat outstanding");
                exp_inv_out = 1'b0;
            end else if (o_valid === 1'b1) begin
                e = exp_q.pop_front();
                if (edge_cnt != e.due) begin
                    n_err++;
                    $display("ERROR: %s came out at edge %0d, due at %0d", e.name, edge_cnt, e.due);
                end
                check_data(e.name, e.data, o_data);
                check_tlast(e.name, e.tlast, o_tlast);
                check_invalid(e.name, e.inv, o_invalid_op);
                exp_inv_out = e.inv;
            end else begin
                check_invalid("idle", 1'b0, o_invalid_op);
                exp_inv_out = 1'b0;
                if (exp_q.size() != 0 && exp_q[0].due <= edge_cnt) begin
                    n_err++;
                    $display("ERROR: %s did not come out when due", exp_q[0].name);
                    void'(exp_q.pop_front());
                end
            end
        end else begin
            // Outputs hold while the clock enable is low
            if (o_valid !== hold_valid) begin
                n_err++;
                $display("ERROR: o_valid changed while the clock enable was low");
            end
            check_data("hold", hold_data, o_data);
            check_tlast("hold", hold_tlast, o_tlast);
            check_invalid("hold", hold_inv, o_invalid_op);
        end
        check_invalid("sticky", exp_sticky, o_invalid_sticky);
        hold_valid = o_valid;
        hold_data  = o_data;
        hold_tlast = o_tlast;
        hold_inv   = o_invalid_op;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic add_vec(string name, fp_op_e op, cmp_pred_e pred,
                           logic [31:0] a, logic [31:0] b, logic [2:0] tl);
        vecs[n_fill].name = name;
        vecs[n_fill].op   = op;
        vecs[n_fill].pred = pred;
        vecs[n_fill].a    = a;
        vecs[n_fill].b    = b;
        vecs[n_fill].tl   = tl;
        n_fill++;
    endtask

    task automatic drive(vec_t v, logic valid, logic en);
        exp_beat_t e;
        @(posedge i_aclk);
        #1;
        i_aclken   = en;
        i_valid    = valid;
        i_cfg_wr   = 1'b0;
        i_op       = v.op;
        i_pred     = v.pred;
        i_a_data   = v.a;
        i_b_data   = v.b;
        i_a_tlast  = v.tl[0];
        i_b_tlast  = v.tl[1];
        i_op_tlast = v.tl[2];
        if (valid && en) begin
            e     = model(v);
            e.due = edge_cnt + `OP_PIPE_DEPTH;
            exp_q.push_back(e);
        end
    endtask

    task automatic write_mode(tlast_mode_e m);
        @(posedge i_aclk);
        #1;
        i_aclken         = 1'b1;
        i_valid          = 1'b0;
        i_cfg_wr         = 1'b1;
        i_cfg_tlast_mode = m;
        cur_mode         = m;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: watchdog expired after %0d ns, %0d beats outstanding",
                 TIMEOUT_NS, exp_q.size());
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        vec_t        v;
        logic [31:0] r;
        int          i;
        int          m;
        int          k;
        i_aclken         = 1'b1;
        i_rst_n          = 1'b0;
        i_valid          = 1'b0;
        i_a_data         = '0;
        i_b_data         = '0;
        i_op             = OP_ABS;
        i_pred           = PRED_UNORD;
        i_a_tlast        = 1'b0;
        i_b_tlast        = 1'b0;
        i_op_tlast       = 1'b0;
        i_cfg_wr         = 1'b0;
        i_cfg_tlast_mode = TLAST_A;
        cur_mode         = TLAST_A;
        lcg_state        = 32'hd242;
        n_err            = 0;
        n_checks         = 0;
        n_fill           = 0;
        exp_inv_out      = 1'b0;

        add_vec("abs_pos_one",  OP_ABS,     PRED_UNORD, 32'h3f80_0000, 32'h0000_0000, 3'b001);
        add_vec("abs_neg_one",  OP_ABS,     PRED_LT,    32'hbf80_0000, 32'h3f80_0000, 3'b000);
        add_vec("abs_neg_zero", OP_ABS,     PRED_EQ,    32'h8000_0000, 32'h0000_0000, 3'b011);
        add_vec("abs_neg_inf",  OP_ABS,     PRED_GT,    32'hff80_0000, 32'h0000_0000, 3'b101);
        add_vec("abs_neg_qnan", OP_ABS,     PRED_CODE,  32'hffc0_0001, 32'h7fc0_0000, 3'b110);
        add_vec("abs_neg_snan", OP_ABS,     PRED_LT,    32'hff80_0010, 32'h7f80_0001, 3'b111);
        add_vec("abs_neg_sub",  OP_ABS,     PRED_GE,    32'h8000_0100, 32'h0000_0001, 3'b001);
        add_vec("lt_neg_pos",   OP_COMPARE, PRED_LT,    32'hbf80_0000, 32'h3f80_0000, 3'b001);
        add_vec("eq_zeros",     OP_COMPARE, PRED_EQ,    32'h0000_0000, 32'h8000_0000, 3'b000);
        add_vec("le_zeros",     OP_COMPARE, PRED_LE,    32'h8000_0000, 32'h0000_0000, 3'b001);
        add_vec("gt_zeros",     OP_COMPARE, PRED_GT,    32'h0000_0000, 32'h8000_0000, 3'b011);
        add_vec("ne_zeros",     OP_COMPARE, PRED_NE,    32'h8000_0000, 32'h0000_0000, 3'b100);
        add_vec("ge_inf_max",   OP_COMPARE, PRED_GE,    32'h7f80_0000, 32'h7f7f_ffff, 3'b001);
        add_vec("lt_ninf_min",  OP_COMPARE, PRED_LT,    32'hff80_0000, 32'hff7f_ffff, 3'b010);
        add_vec("gt_neg_two",   OP_COMPARE, PRED_GT,    32'hc000_0000, 32'hbf80_0000, 3'b001);
        add_vec("eq_sub",       OP_COMPARE, PRED_EQ,    32'h0000_0001, 32'h0000_0001, 3'b111);
        add_vec("lt_sub",       OP_COMPARE, PRED_LT,    32'h8000_0100, 32'h0000_0001, 3'b001);
        add_vec("unord_qnan",   OP_COMPARE, PRED_UNORD, 32'h7fc0_0000, 32'h3f80_0000, 3'b000);
        add_vec("ne_qnan",      OP_COMPARE, PRED_NE,    32'h7fc0_0000, 32'hffc0_0001, 3'b001);
        add_vec("eq_qnan",      OP_COMPARE, PRED_EQ,    32'h3f80_0000, 32'h7fc0_0000, 3'b101);
        add_vec("lt_qnan",      OP_COMPARE, PRED_LT,    32'h3f80_0000, 32'h7fc0_0000, 3'b001);
        add_vec("eq_snan",      OP_COMPARE, PRED_EQ,    32'h7f80_0001, 32'h0000_0000, 3'b000);
        add_vec("code_lt",      OP_COMPARE, PRED_CODE,  32'hbf80_0000, 32'h4000_0000, 3'b001);
        add_vec("code_qnan",    OP_COMPARE, PRED_CODE,  32'h7fc0_0000, 32'h3f80_0000, 3'b011);
        add_vec("code_zeros",   OP_COMPARE, PRED_CODE,  32'h0000_0000, 32'h8000_0000, 3'b001);
        add_vec("code_gt_inf",  OP_COMPARE, PRED_CODE,  32'h7f80_0000, 32'h0000_0000, 3'b110);
        add_vec("ge_equal",     OP_COMPARE, PRED_GE,    32'h4000_0000, 32'h4000_0000, 3'b001);
        add_vec("abs_pos_qnan", OP_ABS,     PRED_NE,    32'h7fc0_0000, 32'h0000_0000, 3'b000);

        repeat (2) @(posedge i_aclk);
        #1;
        i_rst_n = 1'b1;

        // Table back to back with the opcode changing along the way
        for (i = 0; i < N_VEC; i++) begin
            drive(vecs[i], 1'b1, 1'b1);
        end

        // Every merge mode against all tlast combinations
        for (m = 0; m < 6; m++) begin
            write_mode(tlast_mode_e'(m));
            for (k = 0; k < 8; k++) begin
                v    = vecs[k + 16];
                v.tl = 3'(k);
                drive(v, 1'b1, 1'b1);
            end
        end

        for (i = 0; i < N_RAND; i++) begin
            r      = lcg_next();
            v.name = $sformatf("rand_%0d", i);
            v.op   = fp_op_e'(r[0]);
            v.pred = cmp_pred_e'(r[3:1]);
            v.tl   = r[6:4];
            v.a    = rand_operand();
            v.b    = r[7] ? v.a : rand_operand();
            if (r[9:8] == 2'b00) begin
                drive(v, 1'b1, 1'b0);
            end
            if (r[11:10] == 2'b00) begin
                drive(v, 1'b0, 1'b1);
            end
            drive(v, 1'b1, 1'b1);
        end

        drive(v, 1'b0, 1'b1);
        while (exp_q.size() != 0) begin
            @(posedge i_aclk);
        end
        repeat (2) @(posedge i_aclk);

        $display("checks: %0d, errors: %0d", n_checks, n_err);
        if (n_err == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
verilog/fp_ops_pkg.sv
verilog/fp_classify.sv
verilog/fp_compare.sv
verilog/fp_cfg_regs.sv
verilog/fp_issue_stage.sv
verilog/fp_result_stage.sv
verilog/fp_ops_top.sv
verif/tb_fp_ops.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_fp_ops
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
